/* all.f */
+incdir+common
common/mmu_pkg.sv
common/map_cmd_if.sv
common/map_rsp_if.sv
page_table/map_table_ram.sv
source/map_req_port.sv
page_table/page_map_core.sv
source/map_resp_port.sv
source/mmu_map_top.sv
testbench/tb_mmu_map.sv

/* Bender.yml */
package:
  name: mmu_map

sources:
  - include_dirs:
      - common
    files:
      - common/mmu_pkg.sv
      - common/map_cmd_if.sv
      - common/map_rsp_if.sv
      - page_table/map_table_ram.sv
      - source/map_req_port.sv
      - page_table/page_map_core.sv
      - source/map_resp_port.sv
      - source/mmu_map_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_mmu_map.sv

/* testbench/tb_mmu_map.sv */
`default_nettype none
`include "mmu_params.svh"

module tb_mmu_map
  import mmu_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CMDS    = 353;                  // All commands issued over the run
  localparam int CYCLE_LIMIT = 40 * NUM_CMDS + 500;

  logic                   sysclk = 1'b0;
  logic                   arst_n;
  logic                   req;
  logic                   ack;
  mmu_op_e                op;
  logic [`MMU_LA_W-1:0]   la;
  logic [`MMU_WORD_W-1:0] pt_wdata;
  logic [`MMU_WORD_W-1:0] ppn_wdata;
  logic                   resp_req;
  logic                   resp_ack;
  logic [`MMU_WORD_W-1:0] pt;
  logic [`MMU_WORD_W-1:0] ppn;
  logic                   wcinh_n;

  // Reference model of the three memories
  logic [`MMU_WORD_W-1:0] pt_m  [2**`MMU_LA_W];
  logic [`MMU_WORD_W-1:0] ppn_m [2**`MMU_LA_W];
  logic                   inh_m [2**`MMU_INH_AW];
  logic [32:0]            exp_q [$];                 // {pt, ppn, wcinh_n} in command order
  logic [`MMU_LA_W-1:0]   la_pool  [16];
  logic [`MMU_INH_AW-1:0] inh_pool [8];              // Inhibit addresses the PPNs point at
  int  checks = 0;
  int  errors = 0;
  int  cycles = 0;
  bit  slow_resp = 1'b0;                             // Hold resp_ack off for long stretches

  mmu_map_top uut (.*);

  always #10 sysclk = ~sysclk;  // 20 ns period

  always @(posedge sysclk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Four-phase host side, entered and left on a falling edge
  task automatic send_cmd(input mmu_op_e c_op, input logic [10:0] c_la,
                          input logic [15:0] c_pt, input logic [15:0] c_ppn,
                          output int waited);
    waited    = 0;
    op        = c_op;
    la        = c_la;
    pt_wdata  = c_pt;
    ppn_wdata = c_ppn;
    req       = 1'b1;
    do begin
      @(negedge sysclk);
      waited++;
    end while (!ack);
    req = 1'b0;
    do @(negedge sysclk); while (ack);  // Back to zero before the next command
  endtask

  task automatic write_map(input logic [10:0] a, input logic [15:0] d_pt,
                           input logic [15:0] d_ppn);
    int w;
    pt_m[a]  = d_pt;
    ppn_m[a] = d_ppn;
    send_cmd(OP_WR_MAP, a, d_pt, d_ppn, w);
  endtask

  task automatic write_clim(input logic [13:0] a, input logic bit_v);
    int w;
    inh_m[a] = bit_v;
    // Bit 14 is noise, the inhibit RAM never sees it
    send_cmd(OP_WR_CLIM, $urandom, $urandom, {bit_v, 1'($urandom), a}, w);
  endtask

  task automatic translate(input logic [10:0] a, output int waited);
    exp_q.push_back({pt_m[a], ppn_m[a], inh_m[ppn_m[a][13:0]]});  // Queued before issue
    send_cmd(OP_XLATE, a, $urandom, $urandom, waited);
  endtask

  task automatic drain_results();
    while (exp_q.size() != 0 || resp_req || resp_ack)
      @(negedge sysclk);
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("Test %s finished with %0d errors", name, errors - err_start);
  endtask

  // Host responder, checks each result and its stability
  initial begin : responder
    logic [32:0] exp;
    logic [32:0] got;
    int          delay;
    resp_ack = 1'b0;
    @(posedge arst_n);
    forever begin
      @(negedge sysclk);
      if (resp_req) begin
        got = {pt, ppn, wcinh_n};
        checks++;
        assert (exp_q.size() > 0) else begin
          $display("Result arrived at %0t with no translation outstanding", $time);
          errors++;
        end
        if (exp_q.size() > 0) begin
          exp = exp_q.pop_front();
          compare("pt", pt, exp[32:17]);
          compare("ppn", ppn, exp[16:1]);
          compare("wcinh_n", 16'(wcinh_n), 16'(exp[0]));
        end
        delay = slow_resp ? 30 : $urandom_range(4, 0);
        repeat (delay) begin
          @(negedge sysclk);
          compare("pt held", pt, got[32:17]);  // Must not move while resp_req is up
          compare("ppn held", ppn, got[16:1]);
          compare("wcinh_n held", 16'(wcinh_n), 16'(got[0]));
        end
        resp_ack = 1'b1;
        while (resp_req) @(negedge sysclk);
        resp_ack = 1'b0;
      end
    end
  end

  initial begin : main
    int e0;
    int w;
    int max_wait;
    int r;
    logic [13:0] ia;
    void'($urandom(33));
    arst_n    = 1'b0;
    req       = 1'b0;
    op        = OP_WR_MAP;
    la        = '0;
    pt_wdata  = '0;
    ppn_wdata = '0;
    foreach (la_pool[i]) la_pool[i] = $urandom;
    foreach (inh_pool[i]) inh_pool[i] = $urandom;
    repeat (3) @(negedge sysclk);
    arst_n = 1'b1;

    // Idle link stays quiet
    e0 = errors;
    repeat (10) begin
      @(negedge sysclk);
      compare("ack", 16'(ack), 16'd0);
      compare("resp_req", 16'(resp_req), 16'd0);
    end
    report_test("reset_idle", e0);

    // Write then translate the same entry
    e0 = errors;
    write_clim(inh_pool[0], 1'b1);
    write_map(la_pool[0], 16'h5a3c, {2'b01, inh_pool[0]});
    translate(la_pool[0], w);
    drain_results();
    report_test("map_then_xlate", e0);

    // Inhibit lookup over all pools, PPN bit 14 random
    e0 = errors;
    foreach (inh_pool[i]) write_clim(inh_pool[i], $urandom);
    foreach (la_pool[i])
      write_map(la_pool[i], $urandom, {2'($urandom), inh_pool[$urandom_range(7, 0)]});
    foreach (la_pool[i]) translate(la_pool[i], w);
    drain_results();
    report_test("inhibit_lookup", e0);

    // Flip one inhibit bit under a fixed mapping
    e0 = errors;
    ia = inh_pool[1];
    write_clim(ia, 1'b0);
    write_map(la_pool[1], $urandom, {2'b10, ia});
    translate(la_pool[1], w);
    write_clim(ia, 1'b1);
    translate(la_pool[1], w);
    drain_results();
    report_test("inhibit_overwrite", e0);

    // Slow responder backs up the core and then the input buffer
    e0 = errors;
    slow_resp = 1'b1;
    max_wait  = 0;
    repeat (5) begin
      translate(la_pool[$urandom_range(15, 0)], w);
      if (w > max_wait) max_wait = w;
    end
    drain_results();
    slow_resp = 1'b0;
    checks++;
    assert (max_wait > 15) else begin
      $display("Host ack did not stall under response back-pressure (max wait %0d)", max_wait);
      errors++;
    end
    report_test("backpressure", e0);

    // Random mix, all pool entries are mapped by now
    e0 = errors;
    repeat (300) begin
      r = $urandom_range(9, 0);
      if (r < 4)
        translate(la_pool[$urandom_range(15, 0)], w);
      else if (r < 7)
        write_map(la_pool[$urandom_range(15, 0)], $urandom,
                  {2'($urandom), inh_pool[$urandom_range(7, 0)]});
      else
        write_clim(inh_pool[$urandom_range(7, 0)], $urandom);
    end
    drain_results();
    checks++;
    assert (exp_q.size() == 0) else begin
      $display("%0d expected results never arrived", exp_q.size());
      errors++;
    end
    report_test("random_mix", e0);

    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule : tb_mmu_map

`default_nettype wire

/* source/mmu_map_top.sv */
`default_nettype none
`include "mmu_params.svh"

module mmu_map_top
  import mmu_pkg::*;
(
  input  logic                   sysclk,
  input  logic                   arst_n,
  // Command link from the host
  input  logic                   req,
  output logic                   ack,
  input  mmu_op_e                op,
  input  logic [`MMU_LA_W-1:0]   la,
  input  logic [`MMU_WORD_W-1:0] pt_wdata,
  input  logic [`MMU_WORD_W-1:0] ppn_wdata,
  // Translation result link to the host
  output logic                   resp_req,
  input  logic                   resp_ack,
  output logic [`MMU_WORD_W-1:0] pt,
  output logic [`MMU_WORD_W-1:0] ppn,
  output logic                   wcinh_n
);

  map_cmd_if cmd_if ();  // Input side to core
  map_rsp_if rsp_if ();  // Core to output side

  map_req_port u_req_port (
    .sysclk    (sysclk),
    .arst_n    (arst_n),
    .req       (req),
    .ack       (ack),
    .op        (op),
    .la        (la),
    .pt_wdata  (pt_wdata),
    .ppn_wdata (ppn_wdata),
    .cmd       (cmd_if.src)
  );

  page_map_core u_core (
    .sysclk (sysclk),
    .arst_n (arst_n),
    .cmd    (cmd_if.dst),
    .rsp    (rsp_if.src)
  );

  map_resp_port u_resp_port (
    .sysclk   (sysclk),
    .arst_n   (arst_n),
    .rsp      (rsp_if.dst),
    .resp_req (resp_req),
    .resp_ack (resp_ack),
    .pt       (pt),
    .ppn      (ppn),
    .wcinh_n  (wcinh_n)
  );

endmodule : mmu_map_top

`default_nettype wire

/* source/map_resp_port.sv */
`default_nettype none
`include "mmu_params.svh"

module map_resp_port (
  input  logic                   sysclk,
  input  logic                   arst_n,
  map_rsp_if.dst                 rsp,
  output logic                   resp_req,  // Result valid toward the host
  input  logic                   resp_ack,
  output logic [`MMU_WORD_W-1:0] pt,
  output logic [`MMU_WORD_W-1:0] ppn,
  output logic                   wcinh_n
);

  logic                   resp_req_q;
  logic                   rsp_ack_q;
  logic                   load;
  logic [`MMU_WORD_W-1:0] out_pt;
  logic [`MMU_WORD_W-1:0] out_ppn;
  logic                   out_wcinh_n;

  // Take a result only with the host link fully back at zero
  assign load = rsp.req && !rsp_ack_q && !resp_req_q && !resp_ack;

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      resp_req_q <= 1'b0;
      rsp_ack_q  <= 1'b0;
    end else begin
      if (load)
        resp_req_q <= 1'b1;
      else if (resp_req_q && resp_ack)
        resp_req_q <= 1'b0;  // Host has the data
      if (load)
        rsp_ack_q <= 1'b1;   // Core is free once copied
      else if (!rsp.req)
        rsp_ack_q <= 1'b0;
    end
  end

  // Output register
  always_ff @(posedge sysclk) begin
    if (load) begin
      out_pt      <= rsp.pt;
      out_ppn     <= rsp.ppn;
      out_wcinh_n <= rsp.wcinh_n;
    end
  end

  assign rsp.ack  = rsp_ack_q;
  assign resp_req = resp_req_q;
  assign pt       = out_pt;
  assign ppn      = out_ppn;
  assign wcinh_n  = out_wcinh_n;

  // Host sees steady data for the whole request
  a_out_stable: assert property (@(posedge sysclk) disable iff (!arst_n)
    resp_req |=> !resp_req || $stable({pt, ppn, wcinh_n}));

endmodule : map_resp_port

`default_nettype wire

/* page_table/page_map_core.sv */
`default_nettype none
`include "mmu_params.svh"

module page_map_core
  import mmu_pkg::*;
(
  input  logic   sysclk,
  input  logic   arst_n,
  map_cmd_if.dst cmd,
  map_rsp_if.src rsp
);

  map_state_e             state;
  map_state_e             state_nxt;
  logic                   accept;      // Command starts this cycle
  logic                   cmd_ack;
  logic                   map_we;      // PT and PPN write strobe
  logic                   clim_we;     // Inhibit write strobe
  logic [`MMU_INH_AW-1:0] inh_addr;
  logic [`MMU_WORD_W-1:0] pt_rdata;
  logic [`MMU_WORD_W-1:0] ppn_rdata;
  logic [0:0]             inh_rdata;
  logic [`MMU_WORD_W-1:0] res_pt;
  logic [`MMU_WORD_W-1:0] res_ppn;
  logic                   res_wcinh_n;

  // Only take a command once the previous ack has been released
  assign accept  = (state == ST_IDLE) && cmd.req && !cmd_ack;
  assign map_we  = accept && (cmd.op == OP_WR_MAP);
  assign clim_we = accept && (cmd.op == OP_WR_CLIM);

  // Inhibit RAM addressed by write data, or by the PPN just read
  assign inh_addr = (state == ST_MAP_RD) ? ppn_rdata[`MMU_INH_AW-1:0]
                                         : cmd.ppn_wdata[`MMU_INH_AW-1:0];

  map_table_ram #(.ADDR_W(`MMU_LA_W), .DATA_W(`MMU_WORD_W)) pt_ram (
    .sysclk (sysclk),
    .we     (map_we),
    .addr   (cmd.la),
    .wdata  (cmd.pt_wdata),
    .rdata  (pt_rdata)
  );

  map_table_ram #(.ADDR_W(`MMU_LA_W), .DATA_W(`MMU_WORD_W)) ppn_ram (
    .sysclk (sysclk),
    .we     (map_we),
    .addr   (cmd.la),
    .wdata  (cmd.ppn_wdata),
    .rdata  (ppn_rdata)
  );

  // Stores PPN bit 15, bit 14 never reaches the address
  map_table_ram #(.ADDR_W(`MMU_INH_AW), .DATA_W(1)) inh_ram (
    .sysclk (sysclk),
    .we     (clim_we),
    .addr   (inh_addr),
    .wdata  (cmd.ppn_wdata[`MMU_WORD_W-1]),
    .rdata  (inh_rdata)
  );

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:   if (accept && cmd.op == OP_XLATE) state_nxt = ST_MAP_RD;  // Writes stay
      ST_MAP_RD: state_nxt = ST_INH_RD;
      ST_INH_RD: state_nxt = ST_RESULT;
      ST_RESULT: if (rsp.ack) state_nxt = ST_IDLE;  // Output side has the copy
      default:   state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ST_IDLE;
      cmd_ack <= 1'b0;
    end else begin
      state <= state_nxt;
      if (accept)
        cmd_ack <= 1'b1;
      else if (!cmd.req)
        cmd_ack <= 1'b0;  // Four-phase return to zero
    end
  end

  // Result words held through ST_RESULT
  always_ff @(posedge sysclk) begin
    if (state == ST_MAP_RD) begin
      res_pt  <= pt_rdata;
      res_ppn <= ppn_rdata;
    end
    if (state == ST_INH_RD)
      res_wcinh_n <= inh_rdata[0];  // Stored bit drives WCINH_n directly
  end

  assign cmd.ack     = cmd_ack;
  assign rsp.req     = (state == ST_RESULT);
  assign rsp.pt      = res_pt;
  assign rsp.ppn     = res_ppn;
  assign rsp.wcinh_n = res_wcinh_n;

  // A write is acked on the next cycle and leaves the core idle
  a_we_on_accept: assert property (@(posedge sysclk) disable iff (!arst_n)
    (map_we || clim_we) |=> (cmd.ack && state == ST_IDLE));

  // Input side never presents an undefined opcode
  a_op_legal: assert property (@(posedge sysclk) disable iff (!arst_n)
    cmd.req |-> cmd.op inside {OP_WR_MAP, OP_WR_CLIM, OP_XLATE});

endmodule : page_map_core

`default_nettype wire

/* source/map_req_port.sv */
`default_nettype none
`include "mmu_params.svh"

module map_req_port
  import mmu_pkg::*;
(
  input  logic                   sysclk,
  input  logic                   arst_n,
  input  logic                   req,        // Host command request
  output logic                   ack,        // Host command acknowledge
  input  mmu_op_e                op,
  input  logic [`MMU_LA_W-1:0]   la,
  input  logic [`MMU_WORD_W-1:0] pt_wdata,
  input  logic [`MMU_WORD_W-1:0] ppn_wdata,
  map_cmd_if.src                 cmd
);

  logic                   buf_full;   // One-entry buffer holds a command
  logic                   ack_q;
  mmu_op_e                buf_op;
  logic [`MMU_LA_W-1:0]   buf_la;
  logic [`MMU_WORD_W-1:0] buf_pt;
  logic [`MMU_WORD_W-1:0] buf_ppn;
  logic                   load;

  // New host command, buffer free and the core done with the last one
  assign load = req && !ack_q && !buf_full && !cmd.ack;

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      buf_full <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      if (load)
        buf_full <= 1'b1;
      else if (cmd.ack)
        buf_full <= 1'b0;  // Core took it, drop the internal req
      if (load)
        ack_q <= 1'b1;     // Visible the cycle after the capture
      else if (!req)
        ack_q <= 1'b0;     // Host released req
    end
  end

  // Command payload, no reset needed
  always_ff @(posedge sysclk) begin
    if (load) begin
      buf_op  <= op;
      buf_la  <= la;
      buf_pt  <= pt_wdata;
      buf_ppn <= ppn_wdata;
    end
  end

  assign ack           = ack_q;
  assign cmd.req       = buf_full;
  assign cmd.op        = buf_op;
  assign cmd.la        = buf_la;
  assign cmd.pt_wdata  = buf_pt;
  assign cmd.ppn_wdata = buf_ppn;

  // Payload must not move under the core while req stays up
  a_cmd_stable: assert property (@(posedge sysclk) disable iff (!arst_n)
    cmd.req |=> !cmd.req || $stable({buf_op, buf_la, buf_pt, buf_ppn}));

  // Host ack only answers a request seen on the previous edge
  a_ack_needs_req: assert property (@(posedge sysclk) disable iff (!arst_n)
    $rose(ack) |-> $past(req));

endmodule : map_req_port

`default_nettype wire

/* page_table/map_table_ram.sv */
`default_nettype none

// Single-port synchronous RAM, stands in for the static RAM chips
module map_table_ram #(
  parameter int ADDR_W = 11,
  parameter int DATA_W = 16
) (
  input  logic              sysclk,
  input  logic              we,     // Active high write strobe
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0] rdata   // Valid one cycle after addr
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];  // Contents undefined until written

  always_ff @(posedge sysclk) begin
    if (we) begin
      mem[addr] <= wdata;
      rdata     <= wdata;      // Write-first, new data shows on the read port
    end else begin
      rdata <= mem[addr];
    end
  end

  // Read register follows addr every cycle, callers capture what they need

endmodule : map_table_ram

`default_nettype wire

/* common/map_rsp_if.sv */
`default_nettype none
`include "mmu_params.svh"

// One translation result from the core to the output side, four-phase
interface map_rsp_if;

  logic                   req;      // Result valid
  logic                   ack;      // Result copied by the output side
  logic [`MMU_WORD_W-1:0] pt;
  logic [`MMU_WORD_W-1:0] ppn;
  logic                   wcinh_n;  // Active low cache inhibit

  modport src (output req, pt, ppn, wcinh_n, input ack);
  modport dst (input req, pt, ppn, wcinh_n, output ack);

endinterface : map_rsp_if

`default_nettype wire

/* common/map_cmd_if.sv */
`default_nettype none
`include "mmu_params.svh"

// One command from the input side to the core, four-phase
interface map_cmd_if
  import mmu_pkg::*;
();

  logic                   req;        // Command valid, held until ack
  logic                   ack;        // Core has started the command
  mmu_op_e                op;
  logic [`MMU_LA_W-1:0]   la;         // Table index
  logic [`MMU_WORD_W-1:0] pt_wdata;
  logic [`MMU_WORD_W-1:0] ppn_wdata;  // Also carries inhibit address and bit

  modport src (output req, op, la, pt_wdata, ppn_wdata, input ack);
  modport dst (input req, op, la, pt_wdata, ppn_wdata, output ack);

endinterface : map_cmd_if

`default_nettype wire

/* common/mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

  // Host operations, encoding shared with the testbench
  typedef enum logic [1:0] {
    OP_WR_MAP  = 2'd0,  // Write PT and PPN at one logical address
    OP_WR_CLIM = 2'd1,  // Write one cache-inhibit bit
    OP_XLATE   = 2'd2   // Translate a logical address
  } mmu_op_e;
  // Code 2'd3 is not a legal opcode

  // Core sequencer states
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,  // Waiting for a command, writes happen here
    ST_MAP_RD = 2'd1,  // PT/PPN read data is on the RAM outputs
    ST_INH_RD = 2'd2,  // Inhibit read data is on the RAM output
    ST_RESULT = 2'd3   // Result presented until the output side takes it
  } map_state_e;

endpackage : mmu_pkg

`default_nettype wire

/* common/mmu_params.svh */
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// Logical index into PT and PPN, taken from LA bits 20..10
`define MMU_LA_W 11

// PT and PPN word width
`define MMU_WORD_W 16

// Cache-inhibit RAM address, from PPN bits 13..0
`define MMU_INH_AW 14

`endif
